// File: tests/fetch_stim.txt
# Word count, then address and data pairs in hex, then the boot address in hex
# Then the number of words to fetch and the credit return percentage in decimal
8
00000020 00000513
00000024 00100593
00000028 00b50633
0000002c 00c02023
00000030 00000013
00000034 0000006f
000000f8 00100073
000000fc 0000006f
00000020
6
40

// File: all.f
src/obi_pkg.sv
src/fetch_pkg.sv
src/obi_fetch_req.sv
src/obi_sram.sv
src/fetch_buffer.sv
src/fetch_subsys_top.sv
tests/fetch_subsys_tb.sv

// File: tests/fetch_subsys_tb.sv
// Fetch subsystem testbench with stim file loading, data port, fetch, back-pressure and range checks

`timescale 1ns/1ns
`default_nettype none

module fetch_subsys_tb
    import obi_pkg::*;
    import fetch_pkg::*;
();

    localparam int RAM_ADDR_WIDTH = 6;
    localparam int BUF_DEPTH      = 4;
    localparam int OUT_CREDITS    = 2;
    // Byte size of the SRAM, addresses at or above it are out of range
    localparam int RAM_BYTES      = 4 << RAM_ADDR_WIDTH;
    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int SEED           = 7;
    // Edges from the enable sampling edge to the first word
    localparam int FIRST_WORD_LAT = 3;
    localparam int HOLD_CYCLES    = 20;
    localparam int OOR_FETCHES    = 4;
    localparam     STIM_FILE      = "tests/fetch_stim.txt";

    logic        clk_i;
    logic        rst_n_i;
    logic        fetch_en_i;
    obi_addr_t   boot_addr_i;
    logic        data_req_i;
    logic        data_we_i;
    obi_be_t     data_be_i;
    obi_addr_t   data_addr_i;
    obi_data_t   data_wdata_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    obi_data_t   data_rdata_o;
    logic        out_credit_i;
    logic        instr_valid_o;
    fetch_word_t instr_word_o;

    // Stim contents and the reference memory
    obi_addr_t   stim_addr [$];
    obi_data_t   stim_data [$];
    obi_data_t   model_mem [obi_addr_t];
    obi_addr_t   boot_addr;
    int          n_fetch;
    int          stim_pct;

    // Consumer side bookkeeping
    fetch_word_t got_q [$];
    int          tb_credits;
    int          held;
    int          owed;
    int          credit_pct;
    logic        rst_seen;

    int          err_cnt;
    int          test_err_start;
    int          tests_passed;
    int          tests_failed;
    int          watchdog_cycles;
    string       cur_test;
    bit          stim_loaded;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    fetch_subsys_top #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .BUF_DEPTH      (BUF_DEPTH),
        .OUT_CREDITS    (OUT_CREDITS)
    ) u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_en_i    (fetch_en_i),
        .boot_addr_i   (boot_addr_i),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_be_i     (data_be_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .out_credit_i  (out_credit_i),
        .instr_valid_o (instr_valid_o),
        .instr_word_o  (instr_word_o)
    );

    // ----------------------------------------------------------------------
    // Compare and reporting helpers
    // ----------------------------------------------------------------------

    task automatic check_data(input string name, input obi_data_t exp, input obi_data_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fetch(input string name, input fetch_word_t exp,
                               input fetch_word_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_fail(input string what);
        err_cnt++;
        $display("[ERROR] %s: %s", cur_test, what);
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_err_start) begin
            tests_passed++;
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d errors", cur_test, err_cnt - test_err_start);
        end
    endtask

    // Old word with the enabled bytes taken from the new one
    function automatic obi_data_t merge_bytes(input obi_data_t old_w, input obi_data_t new_w,
                                              input obi_be_t be);
        obi_data_t res;
        res = old_w;
        for (int b = 0; b < $bits(obi_be_t); b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Error flag with zero data past the array, else the reference word
    function automatic bit expected_word(input obi_addr_t addr, output fetch_word_t exp);
        exp = '0;
        if (addr >= obi_addr_t'(RAM_BYTES)) begin
            exp[OBI_DATA_W] = 1'b1;
            return 1'b1;
        end
        if (!model_mem.exists(addr)) begin
            return 1'b0;
        end
        exp[OBI_DATA_W-1:0] = model_mem[addr];
        return 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Stim file
    // ----------------------------------------------------------------------

    // Next line that is neither a comment nor empty
    task automatic next_line(input int fd, output string line, output bit ok);
        int rc;
        ok   = 1'b0;
        line = "";
        while (!ok && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line[0] != "#" && line[0] != "\n") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic load_stim(output bit ok);
        int        fd;
        int        rc;
        int        n_words;
        string     line;
        bit        got;
        obi_addr_t a;
        obi_data_t d;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("[ERROR] cannot open stim file %s", STIM_FILE);
        end else begin
            next_line(fd, line, got);
            rc = got ? $sscanf(line, "%d", n_words) : 0;
            ok = (rc == 1);
            for (int i = 0; ok && i < n_words; i++) begin
                next_line(fd, line, got);
                rc = got ? $sscanf(line, "%h %h", a, d) : 0;
                ok = (rc == 2);
                if (ok) begin
                    stim_addr.push_back(a);
                    stim_data.push_back(d);
                end
            end
            // Boot address, fetch count, credit return percentage
            if (ok) begin
                next_line(fd, line, got);
                rc        = got ? $sscanf(line, "%h", a) : 0;
                boot_addr = a;
                ok        = (rc == 1);
            end
            if (ok) begin
                next_line(fd, line, got);
                rc = got ? $sscanf(line, "%d", n_fetch) : 0;
                ok = (rc == 1);
            end
            if (ok) begin
                next_line(fd, line, got);
                rc = got ? $sscanf(line, "%d", stim_pct) : 0;
                ok = (rc == 1) && (stim_addr.size() > 0);
            end
            if (!ok) begin
                $display("[ERROR] stim file %s is short or malformed", STIM_FILE);
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus drivers
    // ----------------------------------------------------------------------

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        rst_n_i    = 1'b0;
        fetch_en_i = 1'b0;
        data_req_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        if (instr_valid_o !== 1'b0 || data_gnt_o !== 1'b0 || data_rvalid_o !== 1'b0) begin
            report_fail("outputs not low while in reset");
        end
        rst_n_i = 1'b1;
    endtask

    // One data port transfer, then an idle cycle for the response
    task automatic data_access(input logic we, input obi_be_t be, input obi_addr_t addr,
                               input obi_data_t wdata, output obi_data_t rdata);
        @(posedge clk_i);
        #1;
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_be_i    = be;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        @(negedge clk_i);
        if (data_gnt_o !== 1'b1) begin
            report_fail("data request not granted in its own cycle");
        end
        if (u_dut.instr_gnt !== 1'b0) begin
            report_fail("instruction grant in a cycle with a data request");
        end
        if (data_rvalid_o !== 1'b0) begin
            report_fail("data rvalid already high in the grant cycle");
        end
        @(posedge clk_i);
        #1;
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
        @(negedge clk_i);
        if (data_rvalid_o !== 1'b1) begin
            report_fail("no data rvalid one cycle after the grant");
        end
        rdata = data_rdata_o;
    endtask

    // Consumer returns only credits it owes, each cycle with credit_pct chance
    always @(posedge clk_i) begin
        rst_seen = rst_n_i;
        #1;
        if (!rst_seen) begin
            out_credit_i = 1'b0;
            owed         = 0;
        end else begin
            if (instr_valid_o === 1'b1) begin
                owed++;
            end
            out_credit_i = 1'b0;
            if (owed > 0 && int'($urandom % 100) < credit_pct) begin
                out_credit_i = 1'b1;
                owed--;
            end
        end
    end

    // Output monitor, credit accounting and buffer occupancy
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            got_q.delete();
            tb_credits = OUT_CREDITS;
            held       = 0;
        end else begin
            if (instr_valid_o === 1'b1) begin
                if (tb_credits == 0) begin
                    report_fail("instr_valid_o while the consumer held no credit");
                end else begin
                    tb_credits--;
                end
                got_q.push_back(instr_word_o);
                held--;
            end
            if (out_credit_i === 1'b1) begin
                tb_credits++;
            end
            if (u_dut.instr_rvalid === 1'b1) begin
                held++;
            end
            if (held > BUF_DEPTH) begin
                report_fail($sformatf("%0d words held, more than the buffer depth", held));
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic load_and_readback();
        obi_data_t rd;
        for (int i = 0; i < stim_addr.size(); i++) begin
            data_access(1'b1, 4'hF, stim_addr[i], stim_data[i], rd);
            model_mem[stim_addr[i]] = stim_data[i];
        end
        for (int i = 0; i < stim_addr.size(); i++) begin
            data_access(1'b0, 4'h0, stim_addr[i], '0, rd);
            check_data($sformatf("%s @%h", cur_test, stim_addr[i]), stim_data[i], rd);
        end
    endtask

    task automatic byte_enable_writes();
        obi_addr_t addr;
        obi_be_t   be;
        obi_data_t wdata;
        obi_data_t exp;
        obi_data_t rd;
        addr = stim_addr[0];
        for (int k = 0; k < 2; k++) begin
            be    = (k == 0) ? 4'b0101 : 4'b1000;
            wdata = (k == 0) ? 32'hA5C3_5A3C : 32'h7E00_0000;
            exp   = merge_bytes(model_mem[addr], wdata, be);
            data_access(1'b1, be, addr, wdata, rd);
            data_access(1'b0, 4'h0, addr, '0, rd);
            check_data($sformatf("%s be=%b @%h", cur_test, be, addr), exp, rd);
            model_mem[addr] = exp;
        end
    endtask

    task automatic run_fetch(input obi_addr_t boot, input int n, input int pct,
                             input int hold, input bit check_lat, input bit with_read);
        int          lat;
        obi_addr_t   addr;
        obi_addr_t   rd_addr;
        obi_data_t   rd;
        fetch_word_t exp;
        @(negedge clk_i);
        credit_pct = (hold > 0) ? 0 : pct;
        @(posedge clk_i);
        #1;
        boot_addr_i = boot;
        fetch_en_i  = 1'b1;
        // Enable and boot address are taken on this edge
        @(posedge clk_i);
        lat = 0;
        do begin
            @(posedge clk_i);
            #1;
            lat++;
        end while (instr_valid_o !== 1'b1);
        if (check_lat && lat != FIRST_WORD_LAT) begin
            report_fail($sformatf("first word after %0d cycles, expected %0d",
                                  lat, FIRST_WORD_LAT));
        end
        if (with_read) begin
            // Data read while instruction requests are still going out
            rd_addr = stim_addr[stim_addr.size() - 1];
            data_access(1'b0, 4'h0, rd_addr, '0, rd);
            check_data($sformatf("%s data @%h", cur_test, rd_addr), model_mem[rd_addr], rd);
        end
        if (hold > 0) begin
            repeat (hold) @(negedge clk_i);
            credit_pct = pct;
        end
        while (got_q.size() < n) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        fetch_en_i = 1'b0;
        for (int i = 0; i < n; i++) begin
            addr = boot + obi_addr_t'(4 * i);
            if (!expected_word(addr, exp)) begin
                report_fail($sformatf("no stim word for fetch address %h", addr));
            end else begin
                check_fetch($sformatf("%s word %0d @%h", cur_test, i, addr), exp, got_q[i]);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        bit stim_ok;
        void'($urandom(SEED));
        rst_n_i      = 1'b0;
        fetch_en_i   = 1'b0;
        boot_addr_i  = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        out_credit_i = 1'b0;
        credit_pct   = 100;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = "setup";
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("Simulation failed");
        end else begin
            // Three full fetch runs plus the short range run
            watchdog_cycles = 50 * (stim_addr.size() + 3 * n_fetch + OOR_FETCHES) + 200;
            stim_loaded     = 1'b1;

            begin_test("load and readback");
            apply_reset();
            load_and_readback();
            end_test();

            begin_test("byte enables");
            byte_enable_writes();
            end_test();

            begin_test("sequential fetch");
            apply_reset();
            run_fetch(boot_addr, n_fetch, 100, 0, 1'b1, 1'b0);
            end_test();

            begin_test("back-pressure");
            apply_reset();
            run_fetch(boot_addr, n_fetch, stim_pct, HOLD_CYCLES, 1'b0, 1'b0);
            end_test();

            // Last two words of the array, then past its end
            begin_test("out of range");
            apply_reset();
            run_fetch(obi_addr_t'(RAM_BYTES - 8), OOR_FETCHES, 100, 0, 1'b0, 1'b0);
            end_test();

            begin_test("arbitration");
            apply_reset();
            run_fetch(boot_addr, n_fetch, 100, 0, 1'b0, 1'b1);
            end_test();

            $display("Tests passed: %0d, failed: %0d, errors: %0d",
                     tests_passed, tests_failed, err_cnt);
            if (err_cnt == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    // Watchdog sized from the stim contents
    initial begin
        wait (stim_loaded);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("[ERROR] watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fetch_subsys_top.sv
// Fetch subsystem top level joining request stage, SRAM and fetch buffer

`timescale 1ns/1ns
`default_nettype none

module fetch_subsys_top
    import obi_pkg::*;
    import fetch_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 6,
    parameter int BUF_DEPTH      = 4,
    parameter int OUT_CREDITS    = 2
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_en_i,
    input  obi_addr_t   boot_addr_i,
    // Data port, driven from outside
    input  logic        data_req_i,
    input  logic        data_we_i,
    input  obi_be_t     data_be_i,
    input  obi_addr_t   data_addr_i,
    input  obi_data_t   data_wdata_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output obi_data_t   data_rdata_o,
    // Downstream consumer
    input  logic        out_credit_i,
    output logic        instr_valid_o,
    output fetch_word_t instr_word_o
);

    // ----------------------------------------------------------------------
    // Instruction OBI link
    // ----------------------------------------------------------------------

    logic      instr_req;
    obi_addr_t instr_addr;
    logic      instr_gnt;
    logic      instr_rvalid;
    obi_data_t instr_rdata;
    logic      instr_err;
    logic      buf_credit;

    // Fetch side is read only with full-word reads, so no we, be or wdata
    // Buffer space is reserved by credits, responses are always accepted

    obi_fetch_req #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_fetch_req (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_en_i   (fetch_en_i),
        .boot_addr_i  (boot_addr_i),
        .buf_credit_i (buf_credit),
        .instr_req_o  (instr_req),
        .instr_addr_o (instr_addr),
        .instr_gnt_i  (instr_gnt)
    );

    obi_sram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_sram (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .instr_err_o    (instr_err)
    );

    fetch_buffer #(
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fetch_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (instr_rvalid),
        .in_data_i     (instr_rdata),
        .in_err_i      (instr_err),
        .buf_credit_o  (buf_credit),
        .out_credit_i  (out_credit_i),
        .instr_valid_o (instr_valid_o),
        .instr_word_o  (instr_word_o)
    );

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
// Fetch response FIFO with upstream credit return and downstream credit-gated output

`timescale 1ns/1ns
`default_nettype none

module fetch_buffer
    import obi_pkg::*;
    import fetch_pkg::*;
#(
    parameter int BUF_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    input  obi_data_t   in_data_i,
    input  logic        in_err_i,
    output logic        buf_credit_o,
    input  logic        out_credit_i,
    output logic        instr_valid_o,
    output fetch_word_t instr_word_o
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    fetch_word_t      mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] out_crd_q;
    logic             push;
    logic             pop;

    // Wrap at BUF_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // ----------------------------------------------------------------------
    // Push and pop
    // ----------------------------------------------------------------------

    // Upstream credits guarantee a free slot for every response
    assign push = in_valid_i;

    // Send only with a stored word and a consumer credit
    assign pop  = (count_q != '0) && (out_crd_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            out_crd_q     <= CRD_W'(OUT_CREDITS);
            instr_valid_o <= 1'b0;
            buf_credit_o  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q   <= count_q + CNT_W'(push) - CNT_W'(pop);
            // Spent per word out, returned by consumer pulses
            out_crd_q <= out_crd_q - CRD_W'(pop) + CRD_W'(out_credit_i);
            // One-cycle strobes per word leaving
            instr_valid_o <= pop;
            buf_credit_o  <= pop;
        end
    end

    // ----------------------------------------------------------------------
    // Storage and output word
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= {in_err_i, in_data_i};
        end
        if (pop) begin
            instr_word_o <= mem[rd_ptr_q];
        end
    end

endmodule

`default_nettype wire

// File: src/obi_sram.sv
// Two-port OBI word SRAM with data-port priority, byte enables and instruction range error

`timescale 1ns/1ns
`default_nettype none

module obi_sram
    import obi_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 6
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Data port
    input  logic      data_req_i,
    input  logic      data_we_i,
    input  obi_be_t   data_be_i,
    input  obi_addr_t data_addr_i,
    input  obi_data_t data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_rvalid_o,
    output obi_data_t data_rdata_o,
    // Instruction port
    input  logic      instr_req_i,
    input  obi_addr_t instr_addr_i,
    output logic      instr_gnt_o,
    output logic      instr_rvalid_o,
    output obi_data_t instr_rdata_o,
    output logic      instr_err_o
);

    localparam int RAM_WORDS = 2 ** RAM_ADDR_WIDTH;

    obi_data_t                 mem [RAM_WORDS];
    obi_data_t                 rdata_q;
    logic [RAM_ADDR_WIDTH-1:0] data_idx;
    logic [RAM_ADDR_WIDTH-1:0] instr_idx;
    logic                      instr_oor;

    // ----------------------------------------------------------------------
    // Arbitration and decode
    // ----------------------------------------------------------------------

    // Data port always wins
    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i && !data_req_i;

    // Word index from bits above the byte offset, data side wraps
    assign data_idx    = data_addr_i[RAM_ADDR_WIDTH+1:2];
    assign instr_idx   = instr_addr_i[RAM_ADDR_WIDTH+1:2];

    // Any upper address bit set means past the end of the array
    assign instr_oor   = |instr_addr_i[OBI_ADDR_W-1:RAM_ADDR_WIDTH+2];

    // ----------------------------------------------------------------------
    // Array access
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        // Byte-masked write from the data side
        if (data_req_i && data_we_i) begin
            for (int b = 0; b < OBI_BE_W; b++) begin
                if (data_be_i[b]) begin
                    mem[data_idx][b*8 +: 8] <= data_wdata_i[b*8 +: 8];
                end
            end
        end

        // One read per cycle, only one port is granted at a time
        if (data_req_i) begin
            if (!data_we_i) begin
                rdata_q <= mem[data_idx];
            end
        end else if (instr_gnt_o) begin
            rdata_q <= instr_oor ? '0 : mem[instr_idx];
        end
    end

    // Response strobes, one cycle after grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_rvalid_o  <= 1'b0;
            instr_rvalid_o <= 1'b0;
            instr_err_o    <= 1'b0;
        end else begin
            data_rvalid_o  <= data_gnt_o;
            instr_rvalid_o <= instr_gnt_o;
            instr_err_o    <= instr_gnt_o && instr_oor;
        end
    end

    // Shared read register feeds both response buses
    assign data_rdata_o  = rdata_q;
    assign instr_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/obi_fetch_req.sv
// Sequential OBI instruction request stage with a credit counter against the fetch buffer

`timescale 1ns/1ns
`default_nettype none

module obi_fetch_req
    import obi_pkg::*;
    import fetch_pkg::*;
#(
    parameter int BUF_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      fetch_en_i,
    input  obi_addr_t boot_addr_i,
    input  logic      buf_credit_i,
    output logic      instr_req_o,
    output obi_addr_t instr_addr_o,
    input  logic      instr_gnt_i
);

    // Counter must hold the full BUF_DEPTH
    localparam int CRD_W = $clog2(BUF_DEPTH + 1);

    fetch_state_e     state_q;
    obi_addr_t        addr_q;
    logic [CRD_W-1:0] credit_q;
    logic             grant;

    // ----------------------------------------------------------------------
    // Request generation
    // ----------------------------------------------------------------------

    // Only request with a free buffer slot reserved
    assign instr_req_o  = (state_q == FETCH_RUN) && fetch_en_i && (credit_q != '0);

    // Address stays put until the grant moves it on
    assign instr_addr_o = addr_q;

    // Handshake completes on req and gnt together
    assign grant        = instr_req_o && instr_gnt_i;

    // ----------------------------------------------------------------------
    // State, address and credits
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= FETCH_IDLE;
            addr_q   <= '0;
            credit_q <= CRD_W'(BUF_DEPTH);
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    // Boot address taken in the cycle enable is first seen
                    if (fetch_en_i) begin
                        state_q <= FETCH_RUN;
                        addr_q  <= boot_addr_i;
                    end
                end
                FETCH_RUN: begin
                    // Next word on every accepted request
                    if (grant) begin
                        addr_q <= addr_q + obi_addr_t'(4);
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase

            // Spend on grant, regain on each word leaving the buffer
            // both may happen in one cycle
            credit_q <= credit_q - CRD_W'(grant) + CRD_W'(buf_credit_i);
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
// Fetch word typedef and the request stage state enum

`default_nettype none

package fetch_pkg;

    // ----------------------------------------------------------------------
    // Fetch word
    // ----------------------------------------------------------------------

    // Error flag on top of a 32-bit instruction
    localparam int FETCH_WORD_W = 33;

    // Bit FETCH_WORD_W-1 is the bus error, the rest is the instruction
    typedef logic [FETCH_WORD_W-1:0] fetch_word_t;

    // ----------------------------------------------------------------------
    // Request stage FSM
    // ----------------------------------------------------------------------

    // Idle until the first enable, then fetch sequentially for good
    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_e;

endpackage

`default_nettype wire

// File: src/obi_pkg.sv
// OBI bus width constants and the address, data and byte-enable vector typedefs

`default_nettype none

package obi_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------

    // Byte address width of both OBI ports
    localparam int OBI_ADDR_W = 32;

    // Read and write data width
    localparam int OBI_DATA_W = 32;

    // One enable per data byte
    localparam int OBI_BE_W   = OBI_DATA_W / 8;

    // ----------------------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------------------

    // Byte address as seen on the bus
    typedef logic [OBI_ADDR_W-1:0] obi_addr_t;

    // Read or write word
    typedef logic [OBI_DATA_W-1:0] obi_data_t;

    // Byte enables, bit n covers data bits 8n+7..8n
    typedef logic [OBI_BE_W-1:0]   obi_be_t;

endpackage

`default_nettype wire
